// File: design/fetch_pkg.sv
// fetch front end shared widths, rv32 opcode encodings and stage bus types
`default_nettype none

package fetch_pkg;

  localparam int INST_WD      = 32;
  localparam int PC_WD        = 32;
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 64;  // two instructions per sram word

  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;  // first fetched instruction
  localparam logic [PC_WD-1:0] PC_STEP     = 32'd4;

  // rv32 major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    OP_ALU,
    OP_ALU_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LUI_AUIPC,
    OP_SYSTEM,
    OP_OTHER
  } op_class_e;

  // redirect from decode back to pre-IF
  typedef struct packed {
    logic             taken;
    logic [PC_WD-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [PC_WD-1:0]   pc;
    logic [INST_WD-1:0] inst;
    op_class_e          op_class;
  } ds_out_t;

endpackage

`default_nettype wire

// File: design/fetch_pc_gen.sv
// pre-IF stage holding the fetch PC, choosing the next PC and strobing the inst sram
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire                                 i_fs_allowin,
  input  wire fetch_pkg::br_bus_t             i_br_bus,
  output logic [fetch_pkg::PC_WD-1:0]         o_fs_pc,
  output logic                                o_inst_sram_ren,
  output logic [fetch_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr
);

  logic                        to_fs_valid;
  logic                        pc_load;
  logic [fetch_pkg::PC_WD-1:0] pc_q;
  logic [fetch_pkg::PC_WD-1:0] seq_pc;
  logic [fetch_pkg::PC_WD-1:0] next_pc;

  // pre-IF always has a request once out of reset
  assign to_fs_valid = i_rst_n;
  assign pc_load     = to_fs_valid && i_fs_allowin;  // IF takes the new pc

  assign seq_pc = pc_q + fetch_pkg::PC_STEP;

  // a taken jal redirect overrides the sequential pc,
  // only raised while IF is handing the jal to decode
  assign next_pc = i_br_bus.taken ? i_br_bus.target : seq_pc;

  // reset one step back so the first fetch lands on PC_RESETVAL
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= fetch_pkg::PC_RESETVAL - fetch_pkg::PC_STEP;
    end else if (pc_load) begin
      pc_q <= next_pc;
    end
  end

  assign o_fs_pc = pc_q;

  // read strobe and pc load are the same event,
  // so the sram word next cycle belongs to the pc held in IF
  assign o_inst_sram_ren  = pc_load;
  assign o_inst_sram_addr = next_pc;

endmodule

`default_nettype wire

// File: design/fetch_if_stage.sv
// IF stage with valid/allowin control and 32-bit half select from the 64-bit sram word
`timescale 1ns/1ps
`default_nettype none

module fetch_if_stage (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire                                 i_ds_allowin,
  input  wire [fetch_pkg::PC_WD-1:0]          i_fs_pc,
  input  wire [fetch_pkg::SRAM_DATA_WD-1:0]   i_inst_sram_rdata,
  output logic                                o_fs_allowin,
  output logic                                o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_t                o_fs_to_ds
);

  logic                          fs_valid;
  logic [fetch_pkg::INST_WD-1:0] inst_lo;
  logic [fetch_pkg::INST_WD-1:0] inst_hi;
  logic [fetch_pkg::INST_WD-1:0] fs_inst;

  // take a new pc when empty, or when the current one moves on to decode
  assign o_fs_allowin     = !fs_valid || i_ds_allowin;
  assign o_fs_to_ds_valid = fs_valid;  // sram data is there the cycle after the pc load

  // pre-IF is valid every cycle out of reset,
  // so once written the stage stays occupied
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else if (o_fs_allowin) begin
      fs_valid <= 1'b1;
    end
  end

  // sram is 64-bit aligned, pc[2] picks the half
  assign inst_lo = i_inst_sram_rdata[fetch_pkg::INST_WD-1:0];
  assign inst_hi = i_inst_sram_rdata[fetch_pkg::SRAM_DATA_WD-1 -: fetch_pkg::INST_WD];
  assign fs_inst = i_fs_pc[2] ? inst_hi : inst_lo;

  assign o_fs_to_ds.inst = fs_inst;
  assign o_fs_to_ds.pc   = i_fs_pc;  // pc register sits in pre-IF, held while IF is full

endmodule

`default_nettype wire

// File: design/fetch_jump_decode.sv
// decode-side stage register with opcode classification and early JAL redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_jump_decode (
  input  wire                        i_clk,
  input  wire                        i_rst_n,
  input  wire                        i_fs_to_ds_valid,
  input  wire fetch_pkg::fs_to_ds_t  i_fs_to_ds,
  input  wire                        i_out_allowin,
  output logic                       o_ds_allowin,
  output fetch_pkg::br_bus_t         o_br_bus,
  output logic                       o_ds_valid,
  output fetch_pkg::ds_out_t         o_ds_out
);

  logic                          ds_valid;
  logic                          ds_accept;
  logic                          is_jal;
  fetch_pkg::op_class_e          op_class;
  logic [fetch_pkg::INST_WD-1:0] inst;
  logic [fetch_pkg::PC_WD-1:0]   j_imm;

  assign inst = i_fs_to_ds.inst;

  assign o_ds_allowin = !ds_valid || i_out_allowin;
  assign ds_accept    = i_fs_to_ds_valid && o_ds_allowin;

  // class from the major opcode only
  always_comb begin
    case (inst[6:0])
      fetch_pkg::OPC_OP:     op_class = fetch_pkg::OP_ALU;
      fetch_pkg::OPC_OP_IMM: op_class = fetch_pkg::OP_ALU_IMM;
      fetch_pkg::OPC_LOAD:   op_class = fetch_pkg::OP_LOAD;
      fetch_pkg::OPC_STORE:  op_class = fetch_pkg::OP_STORE;
      fetch_pkg::OPC_BRANCH: op_class = fetch_pkg::OP_BRANCH;  // not resolved here
      fetch_pkg::OPC_JAL:    op_class = fetch_pkg::OP_JAL;
      fetch_pkg::OPC_JALR:   op_class = fetch_pkg::OP_JALR;
      fetch_pkg::OPC_LUI,
      fetch_pkg::OPC_AUIPC:  op_class = fetch_pkg::OP_LUI_AUIPC;
      fetch_pkg::OPC_SYSTEM: op_class = fetch_pkg::OP_SYSTEM;
      default:               op_class = fetch_pkg::OP_OTHER;
    endcase
  end

  assign is_jal = (op_class == fetch_pkg::OP_JAL);

  // j-type immediate, sign extended
  assign j_imm = {{(fetch_pkg::PC_WD-20){inst[31]}},
                  inst[19:12],
                  inst[20],
                  inst[30:21],
                  1'b0};

  // redirect only in the accept cycle, same edge as the pc load,
  // so nothing past the jal is ever fetched
  assign o_br_bus.taken  = ds_accept && is_jal;
  assign o_br_bus.target = i_fs_to_ds.pc + j_imm;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  // payload holds while the output is stalled
  always_ff @(posedge i_clk) begin
    if (ds_accept) begin
      o_ds_out.pc       <= i_fs_to_ds.pc;
      o_ds_out.inst     <= inst;
      o_ds_out.op_class <= op_class;
    end
  end

  assign o_ds_valid = ds_valid;

endmodule

`default_nettype wire

// File: design/fetch_top.sv
// instruction fetch front end: pre-IF pc generator, IF stage and jump decode
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire                                 i_out_allowin,
  input  wire [fetch_pkg::SRAM_DATA_WD-1:0]   i_inst_sram_rdata,
  output logic                                o_inst_sram_ren,
  output logic [fetch_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  output logic                                o_ds_valid,
  output fetch_pkg::ds_out_t                  o_ds_out
);

  logic                        fs_allowin;
  logic                        ds_allowin;
  logic                        fs_to_ds_valid;
  logic [fetch_pkg::PC_WD-1:0] fs_pc;
  fetch_pkg::fs_to_ds_t        fs_to_ds;
  fetch_pkg::br_bus_t          br_bus;

  fetch_pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_allowin     (fs_allowin),
    .i_br_bus         (br_bus),           // jal redirect from decode
    .o_fs_pc          (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  fetch_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_ds_allowin      (ds_allowin),
    .i_fs_pc           (fs_pc),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_allowin      (fs_allowin),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds        (fs_to_ds)
  );

  fetch_jump_decode u_jump_decode (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds       (fs_to_ds),
    .i_out_allowin    (i_out_allowin),
    .o_ds_allowin     (ds_allowin),
    .o_br_bus         (br_bus),
    .o_ds_valid       (o_ds_valid),
    .o_ds_out         (o_ds_out)
  );

endmodule

`default_nettype wire

// File: verification/fetch_imem_model.sv
// instruction sram model, 512 x 64 bit with synchronous read and a seeded random fill
`timescale 1ns/1ps
`default_nettype none

module fetch_imem_model (
  input  wire         i_clk,
  input  wire         i_ren,
  input  wire  [31:0] i_addr,
  output logic [63:0] o_rdata
);

  logic [63:0] mem [512];  // indexed by addr[11:3], wraps every 4 KB
  int          seed;

  // jal with a small nonzero offset, -32 to +31 instructions
  function automatic logic [31:0] make_jal(input logic [31:0] rnd);
    logic [20:0] off;
    off = {{13{rnd[5]}}, rnd[5:0], 2'b00};
    if (off == '0) begin
      off = 21'd4;
    end
    return {off[20], off[10:1], off[11], off[19:12], rnd[11:7], 7'b110_1111};
  endfunction

  function automatic logic [6:0] known_opcode(input logic [3:0] k);
    case (k)
      4'd0:    return 7'b011_0011;
      4'd1:    return 7'b000_0011;
      4'd2:    return 7'b010_0011;
      4'd3:    return 7'b110_0011;
      4'd4:    return 7'b110_0111;
      4'd5:    return 7'b011_0111;
      4'd6:    return 7'b001_0111;
      4'd7:    return 7'b111_0011;
      default: return 7'b001_0011;
    endcase
  endfunction

  function automatic logic [31:0] next_inst();
    logic [31:0] rnd;
    logic [31:0] pick;
    rnd  = $random(seed);
    pick = $random(seed);
    if (pick[2:0] == 3'd0) begin
      return make_jal(rnd);  // about one half in eight
    end
    if (pick[3]) begin
      return {rnd[31:7], known_opcode(pick[7:4])};
    end
    return rnd;  // fully random opcode bits
  endfunction

  initial begin
    logic [31:0] lo;
    logic [31:0] hi;
    seed = 32'h9fea_4d91;
    for (int i = 0; i < 512; i++) begin
      lo     = next_inst();
      hi     = next_inst();
      mem[i] = {hi, lo};
    end
  end

  // word holds while ren is low
  always @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_addr[11:3]];
    end
  end

endmodule

`default_nettype wire

// File: verification/fetch_checker.sv
// stream checker, models the expected fetch stream and compares the DUT outputs with it
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input  wire                      i_clk,
  input  wire                      i_rst_n,
  input  wire                      i_out_allowin,
  input  wire                      i_inst_sram_ren,
  input  wire [31:0]               i_inst_sram_addr,
  input  wire                      i_ds_valid,
  input  wire fetch_pkg::ds_out_t  i_ds_out,
  output int                       o_delivered
);

  typedef enum logic [2:0] {
    RESET_STATE, SEQ_STREAM, JAL_REDIRECT, CLASSIFY, BACK_PRESSURE, THROUGHPUT
  } test_e;

  int                 checks [6];
  int                 errs [6];
  int                 rst_edges;
  int                 cyc;
  logic [31:0]        exp_pc;
  logic               prev_jal;
  logic               stall_q;
  fetch_pkg::ds_out_t held_q;
  logic [31:0]        req_q [$];  // sram read addresses not yet delivered

  initial begin
    for (int i = 0; i < 6; i++) begin
      checks[i] = 0;
      errs[i]   = 0;
    end
    rst_edges   = 0;
    cyc         = 0;
    exp_pc      = fetch_pkg::PC_RESETVAL;
    prev_jal    = 1'b0;
    stall_q     = 1'b0;
  end

  // rv32 major opcode to class
  function automatic fetch_pkg::op_class_e class_of(input logic [31:0] inst);
    case (inst[6:0])
      7'b011_0011:              return fetch_pkg::OP_ALU;
      7'b001_0011:              return fetch_pkg::OP_ALU_IMM;
      7'b000_0011:              return fetch_pkg::OP_LOAD;
      7'b010_0011:              return fetch_pkg::OP_STORE;
      7'b110_0011:              return fetch_pkg::OP_BRANCH;
      7'b110_1111:              return fetch_pkg::OP_JAL;
      7'b110_0111:              return fetch_pkg::OP_JALR;
      7'b011_0111, 7'b001_0111: return fetch_pkg::OP_LUI_AUIPC;
      7'b111_0011:              return fetch_pkg::OP_SYSTEM;
      default:                  return fetch_pkg::OP_OTHER;
    endcase
  endfunction

  function automatic logic [31:0] jal_offset(input logic [31:0] inst);
    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  task automatic check(input test_e t, input logic [71:0] exp, input logic [71:0] act);
    checks[t]++;
    if (exp !== act) begin
      errs[t]++;
      $display("CHECK FAILED %s: expected %h, actual %h", t.name(), exp, act);
    end
  endtask

  task automatic report_test(input test_e t);
    $display("test %s: %s, %0d checks, %0d errors", t.name(),
             (errs[t] == 0 && checks[t] > 0) ? "ok" : "FAIL", checks[t], errs[t]);
  endtask

  task automatic deliver();
    logic [63:0]          word;
    logic [31:0]          exp_inst;
    logic [31:0]          req_addr;
    fetch_pkg::op_class_e exp_class;
    word      = tb_fetch.u_imem.mem[exp_pc[11:3]];
    exp_inst  = exp_pc[2] ? word[63:32] : word[31:0];  // pc[2] picks the half
    exp_class = class_of(exp_inst);
    if (o_delivered == 0) begin
      check(RESET_STATE, 72'(fetch_pkg::PC_RESETVAL), 72'(i_ds_out.pc));
      report_test(RESET_STATE);
    end else if (prev_jal) begin
      check(JAL_REDIRECT, 72'(exp_pc), 72'(i_ds_out.pc));
    end else begin
      check(SEQ_STREAM, 72'(exp_pc), 72'(i_ds_out.pc));
    end
    if (req_q.size() == 0) begin
      errs[SEQ_STREAM]++;
      $display("instruction at pc %h delivered without any sram read for it", i_ds_out.pc);
    end else begin
      req_addr = req_q.pop_front();
      check(SEQ_STREAM, 72'(exp_pc), 72'(req_addr));  // sram reads follow the stream
    end
    check(SEQ_STREAM, 72'(exp_inst), 72'(i_ds_out.inst));
    check(CLASSIFY, 72'(exp_class), 72'(i_ds_out.op_class));
    prev_jal    = (exp_class == fetch_pkg::OP_JAL);
    exp_pc      = prev_jal ? exp_pc + jal_offset(exp_inst) : exp_pc + 32'd4;
    o_delivered <= o_delivered + 1;
  endtask

  // remaining test lines and the closing count
  task automatic final_report(output int failed_tests);
    failed_tests = 0;
    report_test(SEQ_STREAM);
    report_test(JAL_REDIRECT);
    report_test(CLASSIFY);
    report_test(BACK_PRESSURE);
    for (int i = 0; i < 6; i++) begin
      if (errs[i] != 0 || checks[i] == 0) begin
        failed_tests++;
      end
    end
    $display("tests %0d, ok %0d, bad %0d, deliveries %0d",
             6, 6 - failed_tests, failed_tests, o_delivered);
  endtask

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      rst_edges++;
      if (rst_edges >= 2) begin  // first edge applies the reset
        check(RESET_STATE, '0, 72'(i_ds_valid));
        check(RESET_STATE, '0, 72'(i_inst_sram_ren));
      end
    end else begin
      cyc++;
      if (cyc <= 100) begin
        check(THROUGHPUT, 72'(cyc >= 3), 72'(i_ds_valid));  // valid from edge 2 on
        if (cyc == 100) begin
          report_test(THROUGHPUT);
        end
      end
      if (stall_q) begin
        check(BACK_PRESSURE, 72'({1'b1, held_q}), 72'({i_ds_valid, i_ds_out}));
      end
      if (i_ds_valid && i_out_allowin) begin
        deliver();
      end
      stall_q = i_ds_valid && !i_out_allowin;
      held_q  = i_ds_out;
      if (i_inst_sram_ren) begin
        req_q.push_back(i_inst_sram_addr);
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_fetch.sv
// testbench top for the fetch front end: clock, reset, random output stalls and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

  localparam int NUM_DELIVERIES = 600;
  localparam int MAX_CYCLES     = NUM_DELIVERIES * 2 * 3;  // 2 cycles each, margin of 3

  logic               clk;
  logic               rst_n;
  logic               out_allowin;
  logic [63:0]        sram_rdata;
  logic               sram_ren;
  logic [31:0]        sram_addr;
  logic               ds_valid;
  fetch_pkg::ds_out_t ds_out;
  int                 seed;
  int                 cyc;
  int                 delivered;
  int                 failed_tests;
  logic [31:0]        rnd;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  fetch_top dut (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_out_allowin     (out_allowin),
    .i_inst_sram_rdata (sram_rdata),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .o_ds_valid        (ds_valid),
    .o_ds_out          (ds_out)
  );

  fetch_imem_model u_imem (
    .i_clk   (clk),
    .i_ren   (sram_ren),
    .i_addr  (sram_addr),
    .o_rdata (sram_rdata)
  );

  fetch_checker u_chk (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_out_allowin    (out_allowin),
    .i_inst_sram_ren  (sram_ren),
    .i_inst_sram_addr (sram_addr),
    .i_ds_valid       (ds_valid),
    .i_ds_out         (ds_out),
    .o_delivered      (delivered)
  );

  initial begin
    seed        = 32'h9fea_4d91;
    rst_n       = 1'b0;
    out_allowin = 1'b1;
    cyc         = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (delivered < NUM_DELIVERIES && cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc++;
      rnd = $random(seed);
      out_allowin <= (cyc < 100) || rnd[0];  // no stalls for the first 100 cycles
    end
    if (delivered >= NUM_DELIVERIES) begin
      @(negedge clk);
      u_chk.final_report(failed_tests);
      if (failed_tests == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
    end else begin
      $display("timeout: instruction stream stalled, %0d of %0d deliveries after %0d cycles",
               delivered, NUM_DELIVERIES, cyc);
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/fetch_pkg.sv
design/fetch_pc_gen.sv
design/fetch_if_stage.sv
design/fetch_jump_decode.sv
design/fetch_top.sv
verification/fetch_imem_model.sv
verification/fetch_checker.sv
verification/tb_fetch.sv

// File: run.sh
#!/bin/sh
# build the fetch front end testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_fetch -f sim.f -o tb_fetch_sim \
  || { echo "build error"; exit 1; }
out=$(./obj_dir/tb_fetch_sim) ; echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
